//--- aer_spinn_if.f
+incdir+hw
hw/aer_types_pkg.sv
hw/spinn_types_pkg.sv
hw/aer_in_sync.sv
hw/aer_dump_ctrl.sv
hw/event_mapper.sv
hw/aer_spinn_if.sv
test/aer_spinn_if_tb.sv

//--- Makefile
# Verilator build and run for the aer bridge testbench
# override any variable on the command line, e.g. make run LOG=my.log

VERILATOR ?= verilator
TOP       ?= aer_spinn_if_tb
FLIST     ?= aer_spinn_if.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

FAIL_MSG := Test failures found
PASS_MSG := All tests passed!
SIM_BIN  := $(BUILD_DIR)/V$(TOP)
SRCS     := $(wildcard hw/*.sv hw/*.svh test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/aer_spinn_if_tb.sv
/*
 * aer bridge testbench
 * drives a four-phase sensor bus, takes router keys with a
 * programmable sink and checks each key against the mapping rule
 */
`timescale 1ns/1ps
`default_nettype none

`include "aer_defs.svh"

module aer_spinn_if_tb;

  import aer_types_pkg::*;
  import spinn_types_pkg::*;

  localparam int GO_LOW_EVENTS = 20;
  localparam int RUN_EVENTS    = 200;
  localparam int STALL_EVENTS  = 10;
  localparam int RESUME_EVENTS = 50;
  localparam int TOTAL_EVENTS  = GO_LOW_EVENTS + RUN_EVENTS + 1 + STALL_EVENTS + RESUME_EVENTS;
  // longest single handshake phase including the first stalled event
  localparam int HS_LIMIT      = 2 * `AER_DUMP_CNT + 32;
  localparam int WD_CYCLES     = TOTAL_EVENTS * HS_LIMIT + 2000;

  logic       clk;
  logic       rst;
  logic       go;
  logic       bus_req_n;
  aer_addr_t  bus_data;
  logic       bus_ack_n;
  route_key_t key;
  logic       key_vld;
  logic       key_taken;
  logic       dump_mode;

  // keys still owed by the DUT in arrival order
  route_key_t exp_q[$];
  int         seed;
  int         value_errors;
  int         proto_errors;
  int         keys_seen;
  int         sink_delay;
  logic       sink_stall;

  aer_spinn_if DUT (
    .clk       (clk),
    .rst       (rst),
    .go        (go),
    .dump_mode (dump_mode),
    .bus_req_n (bus_req_n),
    .bus_data  (bus_data),
    .bus_ack_n (bus_ack_n),
    .key       (key),
    .key_vld   (key_vld),
    .key_taken (key_taken)
  );

  // 4 ns period
  initial clk = 1'b0;
  always #2 clk = ~clk;

  // ----------------------------------------
  // reference and compare
  // ----------------------------------------
  // prefix then zero-extended y and x with polarity in bit 0
  function automatic route_key_t expected_key(input aer_addr_t addr);
    route_key_t k;
    k[31:24] = `MAP_KEY_PREFIX;
    k[23:16] = {1'b0, addr[14:8]};
    k[15:8]  = {1'b0, addr[7:1]};
    k[7:1]   = '0;
    k[0]     = addr[0];
    return k;
  endfunction

  task automatic check_key(input route_key_t got, input route_key_t exp, input string what);
    if (got !== exp) begin
      value_errors++;
      $display("** Error at %0t: %s, got %08h expected %08h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      value_errors++;
      $display("** Error at %0t: %s, got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      value_errors++;
      $display("** Error at %0t: %s, got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic report_failure(input string msg);
    proto_errors++;
    $display("FAILURE at %0t: %s", $time, msg);
  endtask

  // ----------------------------------------
  // sender model
  // ----------------------------------------
  task automatic wait_bus_ack(input logic level, input string phase);
    int n;
    n = 0;
    while (bus_ack_n !== level && n < HS_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (bus_ack_n !== level) begin
      report_failure($sformatf("bus acknowledge did not %s within %0d cycles", phase, HS_LIMIT));
    end
  endtask

  // starts on a falling edge and returns with the bus at rest
  task automatic send_event(input aer_addr_t addr);
    // only forwarded events owe a key
    if (go && !dump_mode) begin
      exp_q.push_back(expected_key(addr));
    end
    bus_data  = addr;
    bus_req_n = 1'b0;
    @(negedge clk);
    wait_bus_ack(1'b0, "fall");
    bus_req_n = 1'b1;
    @(negedge clk);
    wait_bus_ack(1'b1, "rise");
  endtask

  task automatic send_random(input int count);
    aer_addr_t addr;
    repeat (count) begin
      addr = aer_addr_t'($random(seed));
      send_event(addr);
    end
  endtask

  // ----------------------------------------
  // key sink and comparison
  // ----------------------------------------
  initial begin : key_sink
    route_key_t held;
    forever begin
      @(negedge clk);
      if (key_vld === 1'b1) begin
        held = key;
        keys_seen++;
        if (exp_q.size() == 0) begin
          report_failure($sformatf("key %08h appeared with no event pending", held));
        end else begin
          check_key(held, exp_q.pop_front(), "mapped key");
        end
        // key must sit still while the sink stalls
        while (sink_stall) begin
          @(negedge clk);
          check_bit(key_vld, 1'b1, "key_vld while sink stalled");
          check_key(key, held, "held key while sink stalled");
        end
        repeat (sink_delay) @(negedge clk);
        key_taken = 1'b1;
        @(negedge clk);
        key_taken = 1'b0;
      end
    end
  end

  initial begin : watchdog
    repeat (WD_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run is stuck", WD_CYCLES);
    $display("errors: %0d value, %0d protocol", value_errors, proto_errors);
    $display("Test failures found");
    $finish;
  end

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  initial begin : main_seq
    int keys_before;
    int n;
    $timeformat(-9, 0, " ns", 0);
    rst          = 1'b1;
    go           = 1'b0;
    bus_req_n    = 1'b1;
    bus_data     = '0;
    key_taken    = 1'b0;
    sink_stall   = 1'b0;
    sink_delay   = 0;
    seed         = 83109;
    value_errors = 0;
    proto_errors = 0;
    keys_seen    = 0;

    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);

    // everything at rest after reset
    check_bit(bus_ack_n, 1'b1, "bus_ack_n after reset");
    check_bit(key_vld, 1'b0, "key_vld after reset");
    check_bit(dump_mode, 1'b0, "dump_mode after reset");

    // disabled bridge drops events
    keys_before = keys_seen;
    send_random(GO_LOW_EVENTS);
    repeat (8) @(negedge clk);
    check_count(keys_seen - keys_before, 0, "keys with go low");

    // prompt sink
    go         = 1'b1;
    sink_delay = 2;
    @(negedge clk);
    keys_before = keys_seen;
    send_random(RUN_EVENTS);
    repeat (8) @(negedge clk);
    check_count(keys_seen - keys_before, RUN_EVENTS, "keys from prompt run");
    check_count(exp_q.size(), 0, "keys still owed after prompt run");

    // stalled sink holds the first event and the bus gets dumped
    sink_stall  = 1'b1;
    keys_before = keys_seen;
    send_random(1);
    check_bit(dump_mode, 1'b1, "dump_mode after watchdog expiry");
    send_random(STALL_EVENTS);
    repeat (2 * `AER_DUMP_CNT + 16) @(negedge clk);
    check_bit(dump_mode, 1'b1, "dump_mode during long stall");
    check_bit(key_vld, 1'b1, "key_vld during long stall");
    check_count(keys_seen - keys_before, 1, "keys during stall");

    // sink resumes so the held key goes and dump ends
    sink_stall = 1'b0;
    n = 0;
    while (dump_mode && n < HS_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (dump_mode) begin
      report_failure("dump_mode stayed high after the sink resumed");
    end
    check_bit(key_vld, 1'b0, "key_vld after held key taken");
    check_count(exp_q.size(), 0, "keys still owed after stall");

    keys_before = keys_seen;
    send_random(RESUME_EVENTS);
    repeat (8) @(negedge clk);
    check_count(keys_seen - keys_before, RESUME_EVENTS, "keys after resume");
    check_count(exp_q.size(), 0, "keys still owed at end");

    $display("errors: %0d value, %0d protocol", value_errors, proto_errors);
    if (value_errors == 0 && proto_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- hw/aer_spinn_if.sv
/*
 * aer to router bridge, input side
 * synchronizer, dump controller and event mapper in a chain
 */
`timescale 1ns/1ps
`default_nettype none

module aer_spinn_if (
  input  wire                         clk,
  input  wire                         rst,

  // control and status
  input  wire                         go,
  output logic                        dump_mode,

  // sensor bus
  input  wire                         bus_req_n,
  input  wire aer_types_pkg::aer_addr_t bus_data,
  output logic                        bus_ack_n,

  // router key output
  output spinn_types_pkg::route_key_t key,
  output logic                        key_vld,
  input  wire                         key_taken
);

  import aer_types_pkg::*;

  // synchronizer to dump controller
  logic      sync_req_n;
  aer_addr_t sync_data;

  // dump controller to mapper
  logic      map_req_n;
  aer_addr_t map_data;
  logic      map_ack_n;

  aer_in_sync u_in_sync (
    .clk        (clk),
    .rst        (rst),
    .bus_req_n  (bus_req_n),
    .bus_data   (bus_data),
    .sync_req_n (sync_req_n),
    .sync_data  (sync_data)
  );

  aer_dump_ctrl u_dump_ctrl (
    .clk        (clk),
    .rst        (rst),
    .go         (go),
    .dump_mode  (dump_mode),
    .sync_req_n (sync_req_n),
    .sync_data  (sync_data),
    .bus_ack_n  (bus_ack_n),
    .map_req_n  (map_req_n),
    .map_data   (map_data),
    .map_ack_n  (map_ack_n)
  );

  event_mapper u_mapper (
    .clk        (clk),
    .rst        (rst),
    .map_req_n  (map_req_n),
    .map_data   (map_data),
    .map_ack_n  (map_ack_n),
    .key        (key),
    .key_vld    (key_vld),
    .key_taken  (key_taken)
  );

endmodule

`default_nettype wire

//--- hw/event_mapper.sv
/*
 * aer event mapper
 * turns each accepted bus address into a router key and holds
 * it until downstream takes it, then completes the handshake
 */
`timescale 1ns/1ps
`default_nettype none

`include "aer_defs.svh"

module event_mapper (
  input  wire                         clk,
  input  wire                         rst,

  // four-phase request from the dump controller
  input  wire                         map_req_n,
  input  wire aer_types_pkg::aer_addr_t map_data,
  output logic                        map_ack_n,

  // key output, level valid with a take strobe
  output spinn_types_pkg::route_key_t key,
  output logic                        key_vld,
  input  wire                         key_taken
);

  import aer_types_pkg::*;
  import spinn_types_pkg::*;

  typedef enum logic [1:0] {
    map_idle,
    map_hold,
    map_release
  } map_state_t;

  map_state_t state;

  aer_coord_t ev_y;
  aer_coord_t ev_x;
  logic       ev_pol;
  key_byte_t  y_byte;
  key_byte_t  x_byte;
  route_key_t key_next;
  logic       accept;

  // ----------------------------------------
  // key construction
  // ----------------------------------------
  assign ev_y   = addr_y(map_data);
  assign ev_x   = addr_x(map_data);
  assign ev_pol = addr_pol(map_data);

  // coordinates zero-extended into their bytes
  assign y_byte = {1'b0, ev_y};
  assign x_byte = {1'b0, ev_x};

  // prefix, y, x, then polarity in the lsb
  assign key_next = {key_byte_t'(`MAP_KEY_PREFIX), y_byte, x_byte, 7'b0, ev_pol};

  // new request while nothing is held
  assign accept = (state == map_idle) && !map_req_n;

  always_ff @(posedge clk) begin
    if (accept) begin
      key <= key_next;
    end
  end

  // ----------------------------------------
  // handshake FSM
  // ----------------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state     <= map_idle;
      key_vld   <= 1'b0;
      map_ack_n <= 1'b1;
    end else begin
      case (state)
        map_idle: begin
          if (accept) begin
            key_vld <= 1'b1;
            state   <= map_hold;
          end
        end
        map_hold: begin
          // no ack until the key has gone,
          // this is the stall the watchdog sees
          if (key_taken) begin
            key_vld   <= 1'b0;
            map_ack_n <= 1'b0;
            state     <= map_release;
          end
        end
        map_release: begin
          // wait for req to return high
          if (map_req_n) begin
            map_ack_n <= 1'b1;
            state     <= map_idle;
          end
        end
        default: begin
          key_vld   <= 1'b0;
          map_ack_n <= 1'b1;
          state     <= map_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/aer_dump_ctrl.sv
/*
 * aer dump controller
 * forwards bus handshakes to the event mapper and, once the
 * mapper stalls for too long, completes bus events locally so
 * the sensor keeps moving
 */
`timescale 1ns/1ps
`default_nettype none

`include "aer_defs.svh"

module aer_dump_ctrl (
  input  wire                       clk,
  input  wire                       rst,

  // control and status
  input  wire                       go,
  output logic                      dump_mode,

  // synchronized bus side
  input  wire                       sync_req_n,
  input  wire aer_types_pkg::aer_addr_t sync_data,
  output logic                      bus_ack_n,

  // mapper side
  output logic                      map_req_n,
  output aer_types_pkg::aer_addr_t  map_data,
  input  wire                       map_ack_n
);

  import aer_types_pkg::*;

  dump_state_t state;
  dump_cnt_t   dump_cnt;
  logic        busy;

  // ----------------------------------------
  // bus acknowledge
  // ----------------------------------------
  always_comb begin
    case (state)
      ds_idle: begin
        if (go) begin
          // mapper acks straight through
          bus_ack_n = map_ack_n;
        end else begin
          // disabled, finish and drop
          bus_ack_n = sync_req_n;
        end
      end
      // dump or wait, event completed here
      default: bus_ack_n = sync_req_n;
    endcase
  end

  // ----------------------------------------
  // mapper request and data
  // ----------------------------------------
  assign map_data = sync_data;

  always_comb begin
    case (state)
      ds_idle: begin
        if (go) begin
          map_req_n = sync_req_n;
        end else begin
          map_req_n = 1'b1;
        end
      end
      // keep the stalled request pending
      ds_dump: map_req_n = 1'b0;
      // release so the mapper can finish its cycle
      default: map_req_n = 1'b1;
    endcase
  end

  // mapper holds a request it has not yet acked
  assign busy = ~map_req_n & map_ack_n;

  // ----------------------------------------
  // stall watchdog
  // ----------------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      dump_cnt <= dump_cnt_t'(`AER_DUMP_CNT);
    end else if (!busy) begin
      // any progress reloads
      dump_cnt <= dump_cnt_t'(`AER_DUMP_CNT);
    end else if (dump_cnt != '0) begin
      dump_cnt <= dump_cnt - 1'b1;
    end
  end

  // status trails the state by one cycle
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      dump_mode <= 1'b0;
    end else begin
      dump_mode <= (state == ds_dump) || (state == ds_wait);
    end
  end

  // ----------------------------------------
  // controller FSM
  // ----------------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= ds_idle;
    end else begin
      case (state)
        ds_idle: begin
          // watchdog expired
          if (dump_cnt == '0) begin
            state <= ds_dump;
          end
        end
        ds_dump: begin
          // mapper finally acked
          if (!busy) begin
            state <= ds_wait;
          end
        end
        ds_wait: begin
          // both handshakes back at rest
          if (sync_req_n && map_ack_n) begin
            state <= ds_idle;
          end
        end
        default: state <= ds_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/aer_in_sync.sv
/*
 * aer input synchronizer
 * brings the asynchronous bus request into the clock domain
 * and latches the event address as the request settles low
 */
`timescale 1ns/1ps
`default_nettype none

module aer_in_sync (
  input  wire                       clk,
  input  wire                       rst,

  // asynchronous sensor bus
  input  wire                       bus_req_n,
  input  wire aer_types_pkg::aer_addr_t bus_data,

  // clean request and stable address
  output logic                      sync_req_n,
  output aer_types_pkg::aer_addr_t  sync_data
);

  // ----------------------------------------
  // request synchronizer
  // ----------------------------------------
  logic req_meta;
  logic req_sync;
  logic req_fall;

  // both stages idle high, same as the bus
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      req_meta <= 1'b1;
      req_sync <= 1'b1;
    end else begin
      req_meta <= bus_req_n;
      req_sync <= req_meta;
    end
  end

  assign sync_req_n = req_sync;

  // ----------------------------------------
  // address capture
  // ----------------------------------------
  // first stage already low, second still high
  // so the address lands on the same edge as sync_req_n falls
  assign req_fall = req_sync & ~req_meta;

  // bus data is stable while bus_req_n is low,
  // held here until the next event starts
  always_ff @(posedge clk) begin
    if (req_fall) begin
      sync_data <= bus_data;
    end
  end

endmodule

`default_nettype wire

//--- hw/spinn_types_pkg.sv
/*
 * router side types
 * routing key as handed to the packet router and its byte fields
 */
`default_nettype none

package spinn_types_pkg;

  // full routing key
  // 31:24 prefix, 23:16 y, 15:8 x, 7:1 zero, 0 polarity
  typedef logic [31:0] route_key_t;

  // one byte field within a key
  typedef logic [7:0] key_byte_t;

endpackage

`default_nettype wire

//--- hw/aer_types_pkg.sv
/*
 * aer side types
 * bus event address, its pixel fields and the dump watchdog types
 */
`default_nettype none

`include "aer_defs.svh"

package aer_types_pkg;

  // raw address as driven on the sensor bus
  // bit 15 unused, 14:8 y, 7:1 x, 0 polarity
  typedef logic [15:0] aer_addr_t;

  // one pixel coordinate
  typedef logic [6:0] aer_coord_t;

  // watchdog counter for the dump controller
  typedef logic [`AER_DUMP_CNT_BITS-1:0] dump_cnt_t;

  // dump controller states
  typedef enum logic [1:0] {
    ds_idle,
    ds_dump,
    ds_wait
  } dump_state_t;

  // ----------------------------------------
  // field extraction
  // ----------------------------------------
  function automatic aer_coord_t addr_y(input aer_addr_t addr);
    return addr[14:8];
  endfunction

  function automatic aer_coord_t addr_x(input aer_addr_t addr);
    return addr[7:1];
  endfunction

  function automatic logic addr_pol(input aer_addr_t addr);
    return addr[0];
  endfunction

endpackage

`default_nettype wire

//--- hw/aer_defs.svh
/*
 * aer bridge build-time constants
 * dump watchdog timing and the fixed routing key prefix
 */
`ifndef AER_DEFS_SVH
`define AER_DEFS_SVH

// ----------------------------------------
// dump watchdog
// ----------------------------------------
// cycles a mapper may sit on an unaccepted request
`define AER_DUMP_CNT 128
// counter must hold AER_DUMP_CNT itself
`define AER_DUMP_CNT_BITS 8

// ----------------------------------------
// routing key
// ----------------------------------------
// top byte of every key sent to the router
`define MAP_KEY_PREFIX 8'hA5

`endif
